// ==== verilog/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int bytes_per_word = 4;
    localparam int offset_width   = 4;  // byte offset inside a line
    localparam int way_count      = 2;

    typedef logic [word_width-1:0] word_t;
    typedef logic [bytes_per_word-1:0] strb_t;
    typedef logic [words_per_line*word_width-1:0] line_t;  // word 0 in the low bits
    typedef logic [31:0] addr_t;

    typedef enum logic {
        op_load,
        op_store
    } req_op_e;

    // one request in flight; the miss path always ends in a re-lookup
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_dirty,
        st_write_back,
        st_miss_clean,
        st_refill,
        st_refill_done
    } cache_state_e;

endpackage

`default_nettype wire

// ==== verilog/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array #(
    parameter  int set_count   = 64,
    localparam int index_width = $clog2(set_count),
    localparam int tag_width   = 32 - dcache_pkg::offset_width - index_width
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   rd_en,
    input  wire logic [index_width-1:0] rd_index,
    input  wire logic [tag_width-1:0]   lookup_tag,
    input  wire logic                   tag_wr_en,
    input  wire logic                   wr_way,
    input  wire logic [index_width-1:0] wr_index,
    input  wire logic [tag_width-1:0]   tag_wr_tag,
    input  wire logic                   tag_wr_dirty,
    input  wire logic                   mark_dirty,
    input  wire logic                   lru_touch,
    output logic                        hit,
    output logic                        hit_way,
    output logic                        victim_way,
    output logic                        victim_dirty,
    output logic [tag_width-1:0]        victim_tag
);

    logic [tag_width-1:0]             tag_q [dcache_pkg::way_count][set_count];
    logic [dcache_pkg::way_count-1:0] valid_q [set_count];
    logic [dcache_pkg::way_count-1:0] dirty_q [set_count];
    logic [set_count-1:0]             lru_q;  // bit names the least recently used way
    logic [index_width-1:0]           index_q;
    logic [dcache_pkg::way_count-1:0] way_hit;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            index_q <= rd_index;
        end
        if (tag_wr_en) begin
            tag_q[wr_way][wr_index] <= tag_wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < set_count; i++) begin
                valid_q[i] <= '0;
                dirty_q[i] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (tag_wr_en) begin
                valid_q[wr_index][wr_way] <= 1'b1;
                dirty_q[wr_index][wr_way] <= tag_wr_dirty;
            end
            if (mark_dirty) begin
                dirty_q[wr_index][hit_way] <= 1'b1;  // store hit
            end
            if (lru_touch) begin
                lru_q[wr_index] <= ~hit_way;
            end
        end
    end

    for (genvar w = 0; w < dcache_pkg::way_count; w++) begin : g_cmp
        assign way_hit[w] = valid_q[index_q][w] && (tag_q[w][index_q] == lookup_tag);
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // lru alone picks the victim; touches after each refill fill empty ways in turn
    assign victim_way   = lru_q[index_q];
    assign victim_dirty = valid_q[index_q][victim_way] && dirty_q[index_q][victim_way];
    assign victim_tag   = tag_q[victim_way][index_q];

    // a line is only refilled after a miss, so a set never holds one tag twice
    a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
        $onehot0(way_hit));

endmodule

`default_nettype wire

// ==== verilog/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array #(
    parameter  int set_count   = 64,
    localparam int index_width = $clog2(set_count),
    localparam int be_width    = dcache_pkg::words_per_line * dcache_pkg::bytes_per_word
) (
    input  wire logic                   clk,
    input  wire logic                   rd_en,
    input  wire logic [index_width-1:0] rd_index,
    input  wire logic                   sel_way,
    input  wire logic                   wr_en,
    input  wire logic                   wr_way,
    input  wire logic [index_width-1:0] wr_index,
    input  wire logic [be_width-1:0]    wr_byte_en,
    input  wire dcache_pkg::line_t      wr_line,
    output dcache_pkg::line_t           sel_line
);

    // one ram per way, byte lanes written independently
    for (genvar w = 0; w < dcache_pkg::way_count; w++) begin : g_way
        dcache_pkg::line_t ram [set_count];
        dcache_pkg::line_t rd_line;
        logic              way_wr;

        assign way_wr = wr_en && (wr_way == 1'(w));

        always_ff @(posedge clk) begin
            for (int b = 0; b < be_width; b++) begin
                if (way_wr && wr_byte_en[b]) begin
                    ram[wr_index][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
            if (rd_en) begin
                rd_line <= ram[rd_index];  // sync read, old data on a same-edge write
            end
        end
    end

    assign sel_line = sel_way ? g_way[1].rd_line : g_way[0].rd_line;

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter  int set_count   = 64,
    localparam int index_width = $clog2(set_count),
    localparam int tag_width   = 32 - dcache_pkg::offset_width - index_width,
    localparam int be_width    = dcache_pkg::words_per_line * dcache_pkg::bytes_per_word
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   req_valid,
    input  wire dcache_pkg::req_op_e    req_op,
    input  wire dcache_pkg::addr_t      req_addr,
    input  wire dcache_pkg::word_t      req_wdata,
    input  wire dcache_pkg::strb_t      req_strb,
    output logic                        busy,
    output logic                        resp_valid,
    output dcache_pkg::word_t           resp_rdata,
    output logic                        mem_rd_req,
    output dcache_pkg::addr_t           mem_rd_addr,
    input  wire logic                   mem_rd_rdy,
    input  wire logic                   mem_ret_valid,
    input  wire dcache_pkg::line_t      mem_ret_data,
    output logic                        mem_wr_req,
    output dcache_pkg::addr_t           mem_wr_addr,
    output dcache_pkg::line_t           mem_wr_data,
    input  wire logic                   mem_wr_rdy,
    input  wire logic                   mem_wr_done,
    output logic                        arr_rd_en,
    output logic [index_width-1:0]      arr_rd_index,
    output logic                        tag_wr_en,
    output logic                        tag_wr_dirty,
    output logic                        mark_dirty,
    output logic                        lru_touch,
    output logic                        wr_way,
    output logic [index_width-1:0]      wr_index,
    output logic [tag_width-1:0]        tag_wr_tag,
    output logic [tag_width-1:0]        lookup_tag,
    input  wire logic                   hit,
    input  wire logic                   hit_way,
    input  wire logic                   victim_way,
    input  wire logic                   victim_dirty,
    input  wire logic [tag_width-1:0]   victim_tag,
    output logic                        sel_way,
    output logic                        data_wr_en,
    output logic [be_width-1:0]         data_wr_byte_en,
    output dcache_pkg::line_t           data_wr_line,
    input  wire dcache_pkg::line_t      sel_line
);

    localparam int byte_sel_width = $clog2(dcache_pkg::bytes_per_word);
    localparam int word_sel_width = $clog2(dcache_pkg::words_per_line);

    dcache_pkg::cache_state_e state, state_next;
    dcache_pkg::req_op_e      req_op_q;
    dcache_pkg::addr_t        req_addr_q;
    dcache_pkg::word_t        req_wdata_q;
    dcache_pkg::strb_t        req_strb_q;
    logic                     miss_way_q;  // victim latched at the miss
    logic                     accept;
    logic                     in_lookup;
    logic                     store_hit;
    logic [index_width-1:0]   req_index;
    logic [tag_width-1:0]     req_tag;
    logic [word_sel_width-1:0] word_sel;

    assign accept    = (state == dcache_pkg::st_idle) && req_valid;
    assign in_lookup = (state == dcache_pkg::st_lookup);
    assign req_index = req_addr_q[dcache_pkg::offset_width +: index_width];
    assign req_tag   = req_addr_q[dcache_pkg::offset_width + index_width +: tag_width];
    assign word_sel  = req_addr_q[byte_sel_width +: word_sel_width];
    assign store_hit = in_lookup && hit && (req_op_q == dcache_pkg::op_store);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op_q    <= req_op;
            req_addr_q  <= req_addr;
            req_wdata_q <= req_wdata;
            req_strb_q  <= req_strb;
        end
        if (in_lookup && !hit) begin
            miss_way_q <= victim_way;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::st_idle:        if (req_valid) state_next = dcache_pkg::st_lookup;
            dcache_pkg::st_lookup: begin
                if (hit) state_next = dcache_pkg::st_idle;
                else if (victim_dirty) state_next = dcache_pkg::st_miss_dirty;
                else state_next = dcache_pkg::st_miss_clean;
            end
            dcache_pkg::st_miss_dirty:  if (mem_wr_rdy) state_next = dcache_pkg::st_write_back;
            dcache_pkg::st_write_back:  if (mem_wr_done) state_next = dcache_pkg::st_miss_clean;
            dcache_pkg::st_miss_clean:  if (mem_rd_rdy) state_next = dcache_pkg::st_refill;
            dcache_pkg::st_refill:      if (mem_ret_valid) state_next = dcache_pkg::st_refill_done;
            dcache_pkg::st_refill_done: state_next = dcache_pkg::st_lookup;
            default:                    state_next = dcache_pkg::st_idle;
        endcase
    end

    assign busy       = (state != dcache_pkg::st_idle);
    assign resp_valid = in_lookup && hit;
    assign resp_rdata = sel_line[word_sel * dcache_pkg::word_width +: dcache_pkg::word_width];

    // array read at acceptance, and again after refill for the re-lookup
    assign arr_rd_en    = accept || (state == dcache_pkg::st_refill_done);
    assign arr_rd_index = (state == dcache_pkg::st_idle) ?
                          req_addr[dcache_pkg::offset_width +: index_width] : req_index;
    assign lookup_tag   = req_tag;

    assign tag_wr_en    = (state == dcache_pkg::st_refill) && mem_ret_valid;
    assign tag_wr_tag   = req_tag;
    assign tag_wr_dirty = 1'b0;  // refilled lines arrive clean
    assign mark_dirty   = store_hit;
    assign lru_touch    = resp_valid;
    assign wr_way       = in_lookup ? hit_way : miss_way_q;
    assign wr_index     = req_index;
    assign sel_way      = in_lookup ? hit_way : miss_way_q;

    assign data_wr_en      = store_hit || tag_wr_en;
    assign data_wr_byte_en = tag_wr_en ? {be_width{1'b1}} :
        {{(be_width - dcache_pkg::bytes_per_word){1'b0}}, req_strb_q}
        << (word_sel * dcache_pkg::bytes_per_word);
    assign data_wr_line    = tag_wr_en ? mem_ret_data :
                             {dcache_pkg::words_per_line{req_wdata_q}};

    assign mem_rd_req  = (state == dcache_pkg::st_miss_clean);
    assign mem_rd_addr = {req_tag, req_index, {dcache_pkg::offset_width{1'b0}}};
    assign mem_wr_req  = (state == dcache_pkg::st_miss_dirty);
    assign mem_wr_addr = {victim_tag, req_index, {dcache_pkg::offset_width{1'b0}}};
    assign mem_wr_data = sel_line;  // victim way selected while in the miss states

    a_mem_req_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req));

    // responses only come out of a lookup that followed an array read
    a_resp_in_lookup: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> in_lookup && $past(arr_rd_en));

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter  int set_count   = 64,
    localparam int index_width = $clog2(set_count),
    localparam int tag_width   = 32 - dcache_pkg::offset_width - index_width,
    localparam int be_width    = dcache_pkg::words_per_line * dcache_pkg::bytes_per_word
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 req_valid,
    input  wire dcache_pkg::req_op_e  req_op,
    input  wire dcache_pkg::addr_t    req_addr,
    input  wire dcache_pkg::word_t    req_wdata,
    input  wire dcache_pkg::strb_t    req_strb,
    output logic                      busy,
    output logic                      resp_valid,
    output dcache_pkg::word_t         resp_rdata,
    output logic                      mem_rd_req,
    output dcache_pkg::addr_t         mem_rd_addr,
    input  wire logic                 mem_rd_rdy,
    input  wire logic                 mem_ret_valid,
    input  wire dcache_pkg::line_t    mem_ret_data,
    output logic                      mem_wr_req,
    output dcache_pkg::addr_t         mem_wr_addr,
    output dcache_pkg::line_t         mem_wr_data,
    input  wire logic                 mem_wr_rdy,
    input  wire logic                 mem_wr_done
);

    logic                   arr_rd_en;
    logic [index_width-1:0] arr_rd_index;
    logic                   tag_wr_en;
    logic                   tag_wr_dirty;
    logic                   mark_dirty;
    logic                   lru_touch;
    logic                   wr_way;
    logic [index_width-1:0] wr_index;
    logic [tag_width-1:0]   tag_wr_tag;
    logic [tag_width-1:0]   lookup_tag;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [tag_width-1:0]   victim_tag;
    logic                   sel_way;
    logic                   data_wr_en;
    logic [be_width-1:0]    data_wr_byte_en;
    dcache_pkg::line_t      data_wr_line;
    dcache_pkg::line_t      sel_line;

    dcache_ctrl #(.set_count(set_count)) ctrl_i (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_strb(req_strb),
        .busy(busy), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr), .mem_rd_rdy(mem_rd_rdy),
        .mem_ret_valid(mem_ret_valid), .mem_ret_data(mem_ret_data),
        .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .mem_wr_rdy(mem_wr_rdy), .mem_wr_done(mem_wr_done),
        .arr_rd_en(arr_rd_en), .arr_rd_index(arr_rd_index),
        .tag_wr_en(tag_wr_en), .tag_wr_dirty(tag_wr_dirty),
        .mark_dirty(mark_dirty), .lru_touch(lru_touch),
        .wr_way(wr_way), .wr_index(wr_index),
        .tag_wr_tag(tag_wr_tag), .lookup_tag(lookup_tag),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .sel_way(sel_way), .data_wr_en(data_wr_en),
        .data_wr_byte_en(data_wr_byte_en), .data_wr_line(data_wr_line),
        .sel_line(sel_line)
    );

    dcache_tag_array #(.set_count(set_count)) tag_array_i (
        .clk(clk), .reset(reset),
        .rd_en(arr_rd_en), .rd_index(arr_rd_index), .lookup_tag(lookup_tag),
        .tag_wr_en(tag_wr_en), .wr_way(wr_way), .wr_index(wr_index),
        .tag_wr_tag(tag_wr_tag), .tag_wr_dirty(tag_wr_dirty),
        .mark_dirty(mark_dirty), .lru_touch(lru_touch),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    dcache_data_array #(.set_count(set_count)) data_array_i (
        .clk(clk),
        .rd_en(arr_rd_en), .rd_index(arr_rd_index), .sel_way(sel_way),
        .wr_en(data_wr_en), .wr_way(wr_way), .wr_index(wr_index),
        .wr_byte_en(data_wr_byte_en), .wr_line(data_wr_line),
        .sel_line(sel_line)
    );

endmodule

`default_nettype wire

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              mem_rd_req,
    input  wire dcache_pkg::addr_t mem_rd_addr,
    output logic                   mem_rd_rdy,
    output logic                   mem_ret_valid,
    output dcache_pkg::line_t      mem_ret_data,
    input  wire logic              mem_wr_req,
    input  wire dcache_pkg::addr_t mem_wr_addr,
    input  wire dcache_pkg::line_t mem_wr_data,
    output logic                   mem_wr_rdy,
    output logic                   mem_wr_done
);

    localparam int ww = dcache_pkg::word_width;

    dcache_pkg::word_t mem [dcache_pkg::addr_t];  // only words written back
    dcache_pkg::addr_t ret_addr;
    int rd_delay;  // -1 when idle
    int ret_delay;
    int wr_delay;
    int done_delay;

    function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5A5A_5A5A;
    endfunction

    function automatic dcache_pkg::line_t read_line(input dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t line;
        for (int i = 0; i < dcache_pkg::words_per_line; i++) begin
            line[i*ww +: ww] = mem_word(line_addr + dcache_pkg::addr_t'(i * 4));
        end
        return line;
    endfunction

    initial begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        rd_delay      = -1;
        ret_delay     = -1;
        wr_delay      = -1;
        done_delay    = -1;
    end

    // read channel: ready after 0..5 cycles, return after another 0..5
    always @(posedge clk) begin
        if (reset) begin
            mem_rd_rdy    <= 1'b0;
            mem_ret_valid <= 1'b0;
            rd_delay = -1;
            ret_delay = -1;
        end else begin
            mem_ret_valid <= 1'b0;
            if (mem_rd_req && mem_rd_rdy) begin
                mem_rd_rdy <= 1'b0;
                ret_addr = mem_rd_addr;
                ret_delay = int'($urandom_range(5, 0));
            end else if (mem_rd_req && !mem_rd_rdy && ret_delay < 0) begin
                if (rd_delay < 0) begin
                    rd_delay = int'($urandom_range(5, 0));
                end
                if (rd_delay == 0) begin
                    mem_rd_rdy <= 1'b1;
                end
                rd_delay--;
            end
            if (ret_delay == 0) begin
                mem_ret_valid <= 1'b1;
                mem_ret_data  <= read_line(ret_addr);
            end
            if (ret_delay >= 0) begin
                ret_delay--;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            mem_wr_rdy  <= 1'b0;
            mem_wr_done <= 1'b0;
            wr_delay = -1;
            done_delay = -1;
        end else begin
            mem_wr_done <= 1'b0;
            if (mem_wr_req && mem_wr_rdy) begin
                mem_wr_rdy <= 1'b0;
                for (int i = 0; i < dcache_pkg::words_per_line; i++) begin
                    mem[mem_wr_addr + dcache_pkg::addr_t'(i * 4)] = mem_wr_data[i*ww +: ww];
                end
                done_delay = int'($urandom_range(5, 0));
            end else if (mem_wr_req && !mem_wr_rdy && done_delay < 0) begin
                if (wr_delay < 0) begin
                    wr_delay = int'($urandom_range(5, 0));
                end
                if (wr_delay == 0) begin
                    mem_wr_rdy <= 1'b1;
                end
                wr_delay--;
            end
            if (done_delay == 0) begin
                mem_wr_done <= 1'b1;  // single pulse
            end
            if (done_delay >= 0) begin
                done_delay--;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int set_count     = 8;
    localparam int line_count    = 32;
    localparam int request_count = 2000;
    localparam int wait_limit    = 200;
    localparam dcache_pkg::addr_t base_addr = 32'h0000_4000;

    logic                clk;
    logic                reset;
    logic                req_valid;
    dcache_pkg::req_op_e req_op;
    dcache_pkg::addr_t   req_addr;
    dcache_pkg::word_t   req_wdata;
    dcache_pkg::strb_t   req_strb;
    logic                busy;
    logic                resp_valid;
    dcache_pkg::word_t   resp_rdata;
    logic                mem_rd_req;
    dcache_pkg::addr_t   mem_rd_addr;
    logic                mem_rd_rdy;
    logic                mem_ret_valid;
    dcache_pkg::line_t   mem_ret_data;
    logic                mem_wr_req;
    dcache_pkg::addr_t   mem_wr_addr;
    dcache_pkg::line_t   mem_wr_data;
    logic                mem_wr_rdy;
    logic                mem_wr_done;

    dcache_pkg::word_t ref_mem [dcache_pkg::addr_t];  // latest value of every stored word
    int pending;
    int error_count;

    dcache_top #(.set_count(set_count)) dut_i (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_strb(req_strb),
        .busy(busy), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr), .mem_rd_rdy(mem_rd_rdy),
        .mem_ret_valid(mem_ret_valid), .mem_ret_data(mem_ret_data),
        .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .mem_wr_rdy(mem_wr_rdy), .mem_wr_done(mem_wr_done)
    );

    dcache_mem_model mem_i (
        .clk(clk), .reset(reset),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr), .mem_rd_rdy(mem_rd_rdy),
        .mem_ret_valid(mem_ret_valid), .mem_ret_data(mem_ret_data),
        .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .mem_wr_rdy(mem_wr_rdy), .mem_wr_done(mem_wr_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            error_count++;
            stop_with_failure($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    function automatic dcache_pkg::word_t ref_word(input dcache_pkg::addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ 32'h5A5A_5A5A;  // memory fill pattern
    endfunction

    function automatic dcache_pkg::line_t ref_line(input dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t line;
        for (int i = 0; i < dcache_pkg::words_per_line; i++) begin
            line[i*32 +: 32] = ref_word(line_addr + dcache_pkg::addr_t'(i * 4));
        end
        return line;
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_word,
                                                       input dcache_pkg::word_t new_word,
                                                       input dcache_pkg::strb_t strb);
        dcache_pkg::word_t merged;
        merged = old_word;
        for (int b = 0; b < dcache_pkg::bytes_per_word; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // called right after a rising edge with the cache idle
    task automatic run_request(input dcache_pkg::req_op_e op, input dcache_pkg::addr_t addr,
                               input dcache_pkg::word_t wdata, input dcache_pkg::strb_t strb,
                               output int latency, output logic mem_seen);
        int cycles;
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_strb  <= strb;
        @(posedge clk);  // acceptance edge
        check_value("busy", 128'(busy), '0);
        req_valid <= 1'b0;
        cycles = 0;
        mem_seen = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            check_value("busy", 128'(busy), 128'(1));  // held up to the response
            if (mem_rd_req) begin
                check_value("mem_rd_addr", 128'(mem_rd_addr), 128'({addr[31:4], 4'h0}));
            end
            if (mem_rd_req || mem_wr_req) begin
                mem_seen = 1'b1;
            end
            if (cycles > wait_limit) begin
                stop_with_failure("timed out waiting for resp_valid after an accepted request");
            end
        end while (!resp_valid);
        if (op == dcache_pkg::op_load) begin
            check_value("resp_rdata", 128'(resp_rdata), 128'(ref_word(addr)));
        end else begin
            ref_mem[addr] = merge_bytes(ref_word(addr), wdata, strb);
        end
        latency = cycles;
    endtask

    // bus rules, write-back contents, one response per request
    always @(posedge clk) begin
        if (!reset) begin
            check_value("mem_rd_req & mem_wr_req", 128'(mem_rd_req && mem_wr_req), '0);
            if (mem_wr_req && mem_wr_rdy) begin
                check_value("mem_wr_addr[3:0]", 128'(mem_wr_addr[3:0]), '0);
                check_value("mem_wr_data", mem_wr_data, ref_line(mem_wr_addr));
            end
            if (resp_valid) begin
                check_value("requests in flight", 128'(pending), 128'(1));
                pending = 0;
            end
            if (req_valid && !busy) begin
                pending++;
            end
        end
    end

    initial begin
        int                  seed_ret;
        int                  line_num;
        int                  word_num;
        int                  latency;
        logic                mem_seen;
        dcache_pkg::addr_t   addr;
        dcache_pkg::req_op_e op;
        dcache_pkg::word_t   wdata;
        dcache_pkg::strb_t   strb;

        pending     = 0;
        error_count = 0;
        seed_ret    = $urandom(71346);
        reset     <= 1'b1;
        req_valid <= 1'b0;
        req_op    <= dcache_pkg::op_load;
        req_addr  <= '0;
        req_wdata <= '0;
        req_strb  <= '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("busy", 128'(busy), '0);
        check_value("resp_valid", 128'(resp_valid), '0);
        check_value("mem_rd_req", 128'(mem_rd_req), '0);
        check_value("mem_wr_req", 128'(mem_wr_req), '0);

        for (int n = 0; n < request_count; n++) begin
            line_num = int'($urandom_range(line_count - 1, 0));  // 4 lines per set
            word_num = int'($urandom_range(3, 0));
            addr  = base_addr + dcache_pkg::addr_t'(line_num * 16 + word_num * 4);
            op    = ($urandom_range(1, 0) == 1) ? dcache_pkg::op_store : dcache_pkg::op_load;
            wdata = $urandom;
            strb  = dcache_pkg::strb_t'($urandom_range(15, 0));
            run_request(op, addr, wdata, strb, latency, mem_seen);
            // repeat at once as a load, always after a store
            if (op == dcache_pkg::op_store || $urandom_range(3, 0) == 0) begin
                run_request(dcache_pkg::op_load, addr, '0, '0, latency, mem_seen);
                check_value("resp_valid latency", 128'(latency), 128'(1));
                check_value("memory request on repeat", 128'(mem_seen), '0);
            end
        end

        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache.f ====
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dcache testbench with Verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f dcache.f --top-module dcache_tb -Mdir obj_dir -o dcache_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/dcache_tb_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAIL" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "TEST PASS" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
